// ==== Makefile ====
SIM  := obj_dir/Vtrs80_glue_tb
SRCS := $(wildcard verilog/*.sv verif/*.sv)

.PHONY: all run clean

all: run

$(SIM): project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module trs80_glue_tb \
		-Mdir obj_dir -f project.f

run: $(SIM)
	$(SIM) +verilator+error+limit+10 | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== project.f ====
verilog/trs80_pkg.sv
verilog/trs80_bus_decode.sv
verilog/trs80_port_regs.sv
verilog/trs80_orch90_dac.sv
verilog/trs80_read_mux.sv
verilog/trs80_glue.sv
verif/trs80_glue_props.sv
verif/trs80_glue_tb.sv

// ==== verif/trs80_glue_props.sv ====
module trs80_glue_props (
   input logic       z80_clk,
   input logic       z80_rst_n,
   input logic       int_n,
   input logic       rd_n,
   input logic [7:0] rd_data,
   input logic       rom_sel,
   input logic       ram_sel,
   input logic       kbd_sel,
   input logic       dsp_sel
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0; // watched by the testbench

   // masks are 0 out of reset, so no interrupt
   int_after_reset: assert property (@(posedge z80_clk) $rose(z80_rst_n) |-> int_n)
   else
   begin
      fail_cnt++;
      $error("int_n low in the first cycle after reset");
   end

   // glue must not drive the bus outside a read
   rd_idle_open: assert property (@(posedge z80_clk) disable iff (!z80_rst_n)
      rd_n |-> (rd_data == trs80_pkg::open_bus))
   else
   begin
      fail_cnt++;
      $error("rd_data driven while rd_n high");
   end

   sel_onehot: assert property (@(posedge z80_clk) disable iff (!z80_rst_n)
      $onehot0({rom_sel, ram_sel, kbd_sel, dsp_sel}))
   else
   begin
      fail_cnt++;
      $error("more than one memory select high");
   end
endmodule

bind trs80_glue trs80_glue_props u_glue_props (
   .z80_clk   (z80_clk),
   .z80_rst_n (z80_rst_n),
   .int_n     (int_n),
   .rd_n      (rd_n),
   .rd_data   (rd_data),
   .rom_sel   (rom_sel),
   .ram_sel   (ram_sel),
   .kbd_sel   (kbd_sel),
   .dsp_sel   (dsp_sel)
);

// ==== verif/trs80_glue_tb.sv ====
module trs80_glue_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int n_addr = 24; // random addresses per map mode
   localparam int n_kbd  = 16;
   localparam int n_dac  = 2;  // samples per channel
   // rough cycle count of all tests, dac windows dominate
   localparam int est_cycles = 8 + 4 * (n_addr + 1) + 8 * 3 + 30 + 2 * n_kbd + 40
                               + 2 * n_dac * 257;
   localparam int watchdog_cycles = 3 * est_cycles;

   logic        z80_clk;
   logic        z80_rst_n;
   logic [15:0] addr;
   logic [7:0]  data_in;
   logic        mreq_n;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  keyb_row [8];
   logic        cass_in;
   logic        rtc_clk_in;
   logic        rom_sel;
   logic        ram_sel;
   logic        kbd_sel;
   logic        dsp_sel;
   logic [1:0]  ram_bank;
   logic [7:0]  rd_data;
   logic        int_n;
   logic        nmi_n;
   logic [1:0]  cass_out;
   logic        cass_out_sel;
   logic        cass_motor_on;
   logic        cpu_fast;
   logic        orch90l_out;
   logic        orch90r_out;

   logic [31:0] lcg_state;
   logic [1:0]  cur_map;     // opreg as last written
   logic [1:0]  cur_mbit;
   logic        cur_fx;
   logic        strobe_seen; // cass_out_sel mid write

   trs80_glue u_trs80_glue (.*);

   initial
   begin
      z80_clk = 1'b0;
      forever #2 z80_clk = ~z80_clk;
   end

   function automatic logic [15:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16]; // low lcg bits are weak
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [15:0] r;
      r = next_rand();
      return r[15:8];
   endfunction

   // bias toward the small kbd/display windows
   function automatic logic [15:0] rand_mem_addr();
      logic [15:0] a;
      logic [15:0] pick;
      a = next_rand();
      pick = next_rand();
      case (pick[1:0])
         2'd1: a = 16'h3800 | (a & 16'h07ff);
         2'd2: a = 16'hf000 | (a & 16'h0fff);
         2'd3: a = a & 16'h3fff;
         default: ;
      endcase
      return a;
   endfunction

   // {rom, ram, kbd, dsp}
   function automatic logic [3:0] selects_for(input logic mq_n, input logic [15:0] a,
                                              input logic [1:0] mm);
      logic lo_rom;
      logic lo_kbd;
      logic lo_dsp;
      lo_rom = a <= 16'h37ff;
      lo_kbd = (a >= 16'h3800) && (a <= 16'h3bff);
      lo_dsp = (a >= 16'h3c00) && (a <= 16'h3fff);
      if (mq_n)
         return 4'b0000;
      case (mm)
         2'd0: return {lo_rom, a >= 16'h4000, lo_kbd, lo_dsp};
         2'd1: return {1'b0, lo_rom || (a >= 16'h4000), lo_kbd, lo_dsp};
         2'd2: return {1'b0, a <= 16'hf3ff, (a >= 16'hf400) && (a <= 16'hf7ff), a >= 16'hf800};
         default: return 4'b0100; // all ram
      endcase
   endfunction

   function automatic logic [1:0] bank_for(input logic fx, input logic [1:0] mb,
                                           input logic a15);
      case ({fx, mb[1]})
         2'b00, 2'b10: return {1'b0, a15};
         2'b01: return a15 ? {1'b1, mb[0]} : 2'b00;
         default: return a15 ? 2'b01 : {1'b1, mb[0]};
      endcase
   endfunction

   function automatic logic [7:0] kbd_rows_or(input logic [7:0] sel, input logic [7:0] rows [8]);
      logic [7:0] v;
      v = 8'h00;
      for (int i = 0; i < 8; i++)
         if (sel[i])
            v |= rows[i];
      return v;
   endfunction

   function automatic logic [7:0] io_value_for(input logic [7:0] port, input logic cass,
                                               input logic [7:0] mode, input logic rtc_pend);
      if (port == 8'hf0)
         return 8'h34; // seek error
      if (port == 8'hf1)
         return 8'h00;
      if (port[7:2] == 6'b111111)
         return {cass, mode[6:1], 1'b0};
      if (port[7:2] == 6'b111000)
         return rtc_pend ? 8'hfb : 8'hff;
      return 8'hff; // nmi status and unused ports
   endfunction

   function automatic int dac_ones_for(input logic [7:0] smp);
      return int'(smp ^ 8'h80);
   endfunction

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic next_edge();
      @(posedge z80_clk);
      #1; // drive just after the edge
   endtask

   task automatic bus_idle();
      mreq_n = 1'b1;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
   endtask

   task automatic io_write(input logic [7:0] port, input logic [7:0] d);
      addr    = {8'h00, port};
      data_in = d;
      iorq_n  = 1'b0;
      wr_n    = 1'b0;
      #1 strobe_seen = cass_out_sel;
      next_edge(); // register loads here
      bus_idle();
   endtask

   task automatic io_read(input logic [7:0] port, output logic [7:0] d);
      addr   = {8'h00, port};
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      #1 d = rd_data;
      next_edge();
      bus_idle();
   endtask

   // selects and bank are checked by the compare process
   task automatic mem_cycle(input logic [15:0] a);
      addr   = a;
      mreq_n = 1'b0;
      rd_n   = 1'b0;
      next_edge();
      bus_idle();
   endtask

   task automatic set_opreg(input logic [7:0] d);
      io_write(8'h84, d);
      cur_map  = d[1:0];
      cur_mbit = d[5:4];
      cur_fx   = d[6];
   endtask

   // inputs settle 1 ns after posedge, so negedge is safe
   always @(negedge z80_clk)
   begin
      if (z80_rst_n)
      begin
         check_eq({rom_sel, ram_sel, kbd_sel, dsp_sel}, selects_for(mreq_n, addr, cur_map),
                  "memory selects");
         if (!mreq_n)
            check_eq(ram_bank, bank_for(cur_fx, cur_mbit, addr[15]), "ram_bank");
      end
   end

   always @(u_trs80_glue.u_glue_props.fail_cnt)
   begin
      if (u_trs80_glue.u_glue_props.fail_cnt != 0)
      begin
         $display("a bound assertion on the glue failed");
         $display("STATUS: FAIL");
         $fatal(1, "assertion failure");
      end
   end

   initial
   begin
      repeat (watchdog_cycles) @(posedge z80_clk);
      $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
   end

   initial
   begin
      logic [7:0]  rd;
      logic [7:0]  rows [8];
      logic [7:0]  ports [8];
      logic [7:0]  mode;
      logic [7:0]  smp;
      logic [15:0] a;
      int          ones;
      ports = '{8'hf0, 8'hf1, 8'h10, 8'he4, 8'he0, 8'hec, 8'hfc, 8'hfd};
      z80_rst_n = 1'b0;
      bus_idle();
      addr       = 16'h0000;
      data_in    = 8'h00;
      cass_in    = 1'b0;
      rtc_clk_in = 1'b1; // idle high, a fall is a tick
      for (int i = 0; i < 8; i++)
         keyb_row[i] = 8'h00;
      lcg_state = 32'd35819;
      cur_map   = 2'b00;
      cur_mbit  = 2'b00;
      cur_fx    = 1'b0;
      repeat (8) @(posedge z80_clk);
      #1 z80_rst_n = 1'b1;
      next_edge();
      check_eq(int_n, 1, "int_n after reset");
      check_eq(cass_out, 2'b10, "cass_out after reset");

      for (int m = 0; m < 4; m++)
      begin
         set_opreg(8'(m));
         for (int i = 0; i < n_addr; i++)
            mem_cycle(rand_mem_addr());
      end

      // bank table, map3 so every address is ram
      for (int f = 0; f < 2; f++)
         for (int mb = 0; mb < 4; mb++)
         begin
            set_opreg({1'b0, f[0], mb[1:0], 2'b00, 2'b11});
            mem_cycle(next_rand() & 16'h7fff);
            mem_cycle(next_rand() | 16'h8000);
         end

      for (int c = 0; c < 4; c++)
      begin
         io_write(8'hfc, 8'(c));
         check_eq(strobe_seen, 1, "cass_out_sel during write");
         check_eq(cass_out, {~c[1], c[0]}, "cass_out"); // bit 1 inverted
         next_edge();
         check_eq(cass_out_sel, 0, "cass_out_sel after write");
      end

      smp  = rand_byte();
      mode = smp | 8'h42; // motor and fast on
      io_write(8'hec, mode);
      check_eq(cass_motor_on, 1, "cass_motor_on set");
      check_eq(cpu_fast, 1, "cpu_fast set");
      mode = mode & 8'hbd;
      io_write(8'hec, mode);
      check_eq(cass_motor_on, 0, "cass_motor_on clear");
      check_eq(cpu_fast, 0, "cpu_fast clear");

      cass_in = 1'b1;
      for (int p = 0; p < 8; p++)
      begin
         io_read(ports[p], rd);
         check_eq(rd, io_value_for(ports[p], cass_in, mode, 1'b0), "i/o read");
         cass_in = ~cass_in;
      end

      // keyboard at 3800 in map0
      set_opreg(8'h00);
      for (int k = 0; k < n_kbd; k++)
      begin
         a = 16'h3800 | (next_rand() & 16'h03ff);
         for (int r = 0; r < 8; r++)
            rows[r] = rand_byte();
         keyb_row = rows;
         addr     = a;
         mreq_n   = 1'b0;
         rd_n     = 1'b0;
         next_edge(); // scan register samples rows here
         for (int r = 0; r < 8; r++)
            keyb_row[r] = rand_byte(); // new rows wait for the next edge
         addr = 16'h3800 | (next_rand() & 16'h03ff); // new address too
         #1 check_eq(rd_data, kbd_rows_or(a[7:0], rows), "keyboard read");
         next_edge();
         bus_idle();
      end

      io_write(8'he0, 8'h04); // enable rtc
      check_eq(int_n, 1, "int_n before rtc tick");
      rtc_clk_in = 1'b0;
      for (int n = 0; n < 4 && int_n; n++)
         next_edge();
      check_eq(int_n, 0, "int_n after rtc fall");
      rtc_clk_in = 1'b1;
      io_read(8'he0, rd);
      check_eq(rd, io_value_for(8'he0, cass_in, mode, 1'b1), "int status pending");
      io_read(8'hec, rd); // ack
      check_eq(int_n, 1, "int_n after ack");
      io_read(8'he0, rd);
      check_eq(rd, io_value_for(8'he0, cass_in, mode, 1'b0), "int status cleared");

      io_write(8'he0, 8'h00);
      rtc_clk_in = 1'b0;
      repeat (6)
      begin
         next_edge();
         check_eq(int_n, 1, "int_n with mask clear");
      end
      rtc_clk_in = 1'b1;
      io_read(8'he0, rd);
      check_eq(rd, io_value_for(8'he0, cass_in, mode, 1'b1), "masked int status");
      io_read(8'hec, rd);
      io_write(8'he4, 8'hff);
      check_eq(nmi_n, 1, "nmi_n with no sources");

      for (int ch = 0; ch < 2; ch++)
         for (int k = 0; k < n_dac; k++)
         begin
            smp = rand_byte();
            io_write(ch ? 8'h79 : 8'h75, smp);
            ones = 0;
            repeat (256)
            begin
               next_edge();
               ones += ch ? int'(orch90r_out) : int'(orch90l_out);
            end
            check_eq(ones, dac_ones_for(smp), "orch90 ones in 256 cycles");
         end

      $display("STATUS: PASS");
      $finish;
   end
endmodule

// ==== verilog/trs80_bus_decode.sv ====
module trs80_bus_decode (
   input  logic [trs80_pkg::addr_w-1:0] addr,
   input  logic                         mreq_n,
   input  logic                         iorq_n,
   input  trs80_pkg::map_mode_e         map_mode,
   input  logic [1:0]                   mbit,
   input  logic                         fxupmem,
   output logic                         rom_sel,
   output logic                         ram_sel,
   output logic                         kbd_sel,
   output logic                         dsp_sel,
   output logic [1:0]                   ram_bank,
   output trs80_pkg::io_port_e          io_port
);

   logic lo_rom; // 0000-37ff
   logic lo_kbd; // 3800-3bff
   logic lo_dsp; // 3c00-3fff
   logic hi_kbd; // f400-f7ff
   logic hi_dsp; // f800-ffff

   assign lo_rom = addr < trs80_pkg::kbd_lo_base;
   assign lo_kbd = (addr >= trs80_pkg::kbd_lo_base) && (addr < trs80_pkg::dsp_lo_base);
   assign lo_dsp = (addr >= trs80_pkg::dsp_lo_base) && (addr < trs80_pkg::ram_lo_base);
   assign hi_kbd = (addr >= trs80_pkg::kbd_hi_base) && (addr < trs80_pkg::dsp_hi_base);
   assign hi_dsp = addr >= trs80_pkg::dsp_hi_base;

   always_comb
   begin
      rom_sel = 1'b0;
      ram_sel = 1'b0;
      kbd_sel = 1'b0;
      dsp_sel = 1'b0;
      if (!mreq_n)
      begin
         case (map_mode)
            trs80_pkg::map0:
            begin
               rom_sel = lo_rom;
               kbd_sel = lo_kbd;
               dsp_sel = lo_dsp;
               ram_sel = addr >= trs80_pkg::ram_lo_base; // 48k
            end
            trs80_pkg::map1:
            begin
               kbd_sel = lo_kbd;
               dsp_sel = lo_dsp;
               ram_sel = lo_rom || (addr >= trs80_pkg::ram_lo_base); // 62k, hole at 3800
            end
            trs80_pkg::map2:
            begin
               kbd_sel = hi_kbd;
               dsp_sel = hi_dsp;
               ram_sel = addr < trs80_pkg::kbd_hi_base; // 61k
            end
            default: ram_sel = 1'b1; // map3, 64k ram
         endcase
      end
   end

   // bank from fxupmem, mbit and a15
   always_comb
   begin
      if (!mbit[1])
         ram_bank = {1'b0, addr[15]}; // banking off
      else if (!fxupmem)
         ram_bank = addr[15] ? {1'b1, mbit[0]} : 2'b00; // maps 2/3, upper 32k swapped
      else
         ram_bank = addr[15] ? 2'b01 : {1'b1, mbit[0]}; // maps 6/7, lower 32k swapped
   end

   // the 4-port groups ignore a1:a0
   always_comb
   begin
      io_port = trs80_pkg::port_none;
      if (!iorq_n)
      begin
         if (addr[7:0] == trs80_pkg::io_orch_l)
            io_port = trs80_pkg::port_orch_l;
         else if (addr[7:0] == trs80_pkg::io_orch_r)
            io_port = trs80_pkg::port_orch_r;
         else if (addr[7:2] == trs80_pkg::io_opreg[7:2])
            io_port = trs80_pkg::port_opreg;
         else if (addr[7:2] == trs80_pkg::io_int[7:2])
            io_port = trs80_pkg::port_int;
         else if (addr[7:2] == trs80_pkg::io_nmi[7:2])
            io_port = trs80_pkg::port_nmi;
         else if (addr[7:2] == trs80_pkg::io_mod_rtc[7:2])
            io_port = trs80_pkg::port_mod_rtc;
         else if (addr[7:0] == trs80_pkg::io_fdc_stat)
            io_port = trs80_pkg::port_fdc_stat;
         else if (addr[7:0] == trs80_pkg::io_fdc_track)
            io_port = trs80_pkg::port_fdc_track;
         else if (addr[7:2] == trs80_pkg::io_cass[7:2])
            io_port = trs80_pkg::port_cass;
      end
   end

endmodule

// ==== verilog/trs80_glue.sv ====
module trs80_glue (
   input  logic                         z80_clk,
   input  logic                         z80_rst_n,
   input  logic [trs80_pkg::addr_w-1:0] addr,
   input  logic [trs80_pkg::data_w-1:0] data_in,
   input  logic                         mreq_n,
   input  logic                         iorq_n,
   input  logic                         rd_n,
   input  logic                         wr_n,
   input  logic [trs80_pkg::data_w-1:0] keyb_row [8],
   input  logic                         cass_in,
   input  logic                         rtc_clk_in,
   output logic                         rom_sel,
   output logic                         ram_sel,
   output logic                         kbd_sel,
   output logic                         dsp_sel,
   output logic [1:0]                   ram_bank,
   output logic [trs80_pkg::data_w-1:0] rd_data,
   output logic                         int_n,
   output logic                         nmi_n,
   output logic [1:0]                   cass_out,
   output logic                         cass_out_sel,
   output logic                         cass_motor_on,
   output logic                         cpu_fast,
   output logic                         orch90l_out,
   output logic                         orch90r_out
);

   trs80_pkg::io_port_e          io_port;
   trs80_pkg::map_mode_e         map_mode;
   logic [1:0]                   mbit;
   logic                         fxupmem;
   logic [trs80_pkg::data_w-1:0] int_mask;
   logic [trs80_pkg::data_w-1:0] nmi_mask;
   logic [5:0]                   mode_bits; // mode reg bits 6:1
   logic                         rtc_int;

   assign cass_motor_on = mode_bits[0]; // mode bit 1
   assign cpu_fast      = mode_bits[5]; // mode bit 6

   trs80_bus_decode u_bus_decode (
      .addr     (addr),
      .mreq_n   (mreq_n),
      .iorq_n   (iorq_n),
      .map_mode (map_mode),
      .mbit     (mbit),
      .fxupmem  (fxupmem),
      .rom_sel  (rom_sel),
      .ram_sel  (ram_sel),
      .kbd_sel  (kbd_sel),
      .dsp_sel  (dsp_sel),
      .ram_bank (ram_bank),
      .io_port  (io_port)
   );

   trs80_port_regs u_port_regs (
      .z80_clk      (z80_clk),
      .z80_rst_n    (z80_rst_n),
      .wr_n         (wr_n),
      .rd_n         (rd_n),
      .io_port      (io_port),
      .data_in      (data_in),
      .rtc_clk_in   (rtc_clk_in),
      .map_mode     (map_mode),
      .mbit         (mbit),
      .fxupmem      (fxupmem),
      .int_mask     (int_mask),
      .nmi_mask     (nmi_mask),
      .mode_bits    (mode_bits),
      .cass_out     (cass_out),
      .cass_out_sel (cass_out_sel),
      .rtc_int      (rtc_int)
   );

   trs80_orch90_dac u_orch90_dac (
      .z80_clk     (z80_clk),
      .z80_rst_n   (z80_rst_n),
      .wr_n        (wr_n),
      .io_port     (io_port),
      .data_in     (data_in),
      .orch90l_out (orch90l_out),
      .orch90r_out (orch90r_out)
   );

   trs80_read_mux u_read_mux (
      .z80_clk   (z80_clk),
      .rd_n      (rd_n),
      .addr      (addr),
      .keyb_row  (keyb_row),
      .kbd_sel   (kbd_sel),
      .io_port   (io_port),
      .int_mask  (int_mask),
      .nmi_mask  (nmi_mask),
      .mode_bits (mode_bits),
      .rtc_int   (rtc_int),
      .cass_in   (cass_in),
      .rd_data   (rd_data),
      .int_n     (int_n),
      .nmi_n     (nmi_n)
   );
endmodule

// ==== verilog/trs80_orch90_dac.sv ====
module trs80_orch90_dac (
   input  logic                         z80_clk,
   input  logic                         z80_rst_n,
   input  logic                         wr_n,
   input  trs80_pkg::io_port_e          io_port,
   input  logic [trs80_pkg::data_w-1:0] data_in,
   output logic                         orch90l_out,
   output logic                         orch90r_out
);

   logic [trs80_pkg::data_w-1:0] sample [2]; // [0] left, [1] right
   logic [trs80_pkg::data_w-1:0] acc    [2];
   logic [trs80_pkg::data_w:0]   sum    [2]; // msb is the carry
   logic [1:0]                   wr_ch;
   logic [1:0]                   pdm_q;

   assign wr_ch[0] = !wr_n && (io_port == trs80_pkg::port_orch_l);
   assign wr_ch[1] = !wr_n && (io_port == trs80_pkg::port_orch_r);

   always_comb
   begin
      for (int i = 0; i < 2; i++)
         sum[i] = {1'b0, acc[i]} + {1'b0, sample[i] ^ trs80_pkg::pdm_bias};
   end

   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         for (int i = 0; i < 2; i++)
         begin
            sample[i] <= '0;
            acc[i]    <= '0;
         end
         pdm_q <= 2'b00;
      end
      else
      begin
         for (int i = 0; i < 2; i++)
         begin
            if (wr_ch[i])
               sample[i] <= data_in;
            acc[i]   <= sum[i][trs80_pkg::data_w-1:0];
            pdm_q[i] <= sum[i][trs80_pkg::data_w]; // one per overflow
         end
      end
   end

   assign orch90l_out = pdm_q[0];
   assign orch90r_out = pdm_q[1];
endmodule

// ==== verilog/trs80_pkg.sv ====
package trs80_pkg;

   // z80 bus widths
   localparam int addr_w = 16;
   localparam int data_w = 8;

   // value seen on an undriven data bus
   localparam logic [data_w-1:0] open_bus = 8'hff;

   // no real fdc, so status is fixed
   localparam logic [data_w-1:0] fdc_stat_val  = 8'h34; // seek error
   localparam logic [data_w-1:0] fdc_track_val = 8'h00;

   // orchestra-90 samples are signed, flip msb for the pdm
   localparam logic [data_w-1:0] pdm_bias = 8'h80;

   // i/o port numbers, the 4-port groups decode on bits 7:2 only
   localparam logic [7:0] io_opreg     = 8'h84; // 84-87
   localparam logic [7:0] io_int       = 8'he0; // e0-e3
   localparam logic [7:0] io_nmi       = 8'he4; // e4-e7
   localparam logic [7:0] io_mod_rtc   = 8'hec; // ec-ef
   localparam logic [7:0] io_fdc_stat  = 8'hf0;
   localparam logic [7:0] io_fdc_track = 8'hf1;
   localparam logic [7:0] io_cass      = 8'hfc; // fc-ff
   localparam logic [7:0] io_orch_l    = 8'h75;
   localparam logic [7:0] io_orch_r    = 8'h79;

   // memory map boundaries
   localparam logic [addr_w-1:0] kbd_lo_base = 16'h3800; // rom below this
   localparam logic [addr_w-1:0] dsp_lo_base = 16'h3c00;
   localparam logic [addr_w-1:0] ram_lo_base = 16'h4000;
   localparam logic [addr_w-1:0] kbd_hi_base = 16'hf400; // map2 keyboard
   localparam logic [addr_w-1:0] dsp_hi_base = 16'hf800; // map2 display, 2k

   // opreg bits 1:0
   typedef enum logic [1:0] {
      map0 = 2'b00, // rom, kbd and display low, ram above
      map1 = 2'b01, // like map0 but ram under the rom
      map2 = 2'b10, // ram low, kbd and display high
      map3 = 2'b11  // all ram
   } map_mode_e;

   // decoded i/o port, port_none outside an iorq cycle
   typedef enum logic [3:0] {
      port_none,
      port_opreg,
      port_int,
      port_nmi,
      port_mod_rtc,
      port_fdc_stat,
      port_fdc_track,
      port_cass,
      port_orch_l,
      port_orch_r
   } io_port_e;

endpackage

// ==== verilog/trs80_port_regs.sv ====
module trs80_port_regs (
   input  logic                         z80_clk,
   input  logic                         z80_rst_n,
   input  logic                         wr_n,
   input  logic                         rd_n,
   input  trs80_pkg::io_port_e          io_port,
   input  logic [trs80_pkg::data_w-1:0] data_in,
   input  logic                         rtc_clk_in,
   output trs80_pkg::map_mode_e         map_mode,
   output logic [1:0]                   mbit,
   output logic                         fxupmem,
   output logic [trs80_pkg::data_w-1:0] int_mask,
   output logic [trs80_pkg::data_w-1:0] nmi_mask,
   output logic [5:0]                   mode_bits,
   output logic [1:0]                   cass_out,
   output logic                         cass_out_sel,
   output logic                         rtc_int
);

   logic       wr_opreg;
   logic       wr_int;
   logic       wr_nmi;
   logic       wr_mod;
   logic       wr_cass;
   logic       rd_rtc;    // reading ec acks the rtc
   logic [1:0] cass_reg;
   logic [1:0] rtc_sync;  // [1] is the synchronized level
   logic       rtc_last;  // previous synchronized level
   logic       rtc_fall;

   assign wr_opreg = !wr_n && (io_port == trs80_pkg::port_opreg);
   assign wr_int   = !wr_n && (io_port == trs80_pkg::port_int);
   assign wr_nmi   = !wr_n && (io_port == trs80_pkg::port_nmi);
   assign wr_mod   = !wr_n && (io_port == trs80_pkg::port_mod_rtc);
   assign wr_cass  = !wr_n && (io_port == trs80_pkg::port_cass);
   assign rd_rtc   = !rd_n && (io_port == trs80_pkg::port_mod_rtc);

   assign rtc_fall = rtc_last && !rtc_sync[1];

   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         map_mode  <= trs80_pkg::map0;
         mbit      <= 2'b00;
         fxupmem   <= 1'b0;
         int_mask  <= '0;
         nmi_mask  <= '0;
         mode_bits <= '0;
         cass_reg  <= 2'b00;
      end
      else
      begin
         if (wr_opreg)
         begin
            map_mode <= trs80_pkg::map_mode_e'(data_in[1:0]);
            mbit     <= data_in[5:4];
            fxupmem  <= data_in[6]; // bits 2, 3, 7 are video only
         end
         if (wr_int)
            int_mask <= data_in;
         if (wr_nmi)
            nmi_mask <= data_in;
         if (wr_mod)
            mode_bits <= data_in[6:1];
         if (wr_cass)
            cass_reg <= data_in[1:0];
      end
   end

   // rtc: 2 sync flops, edge detect, latch until acked
   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         rtc_sync <= 2'b00;
         rtc_last <= 1'b0;
         rtc_int  <= 1'b0;
      end
      else
      begin
         rtc_sync <= {rtc_sync[0], rtc_clk_in};
         rtc_last <= rtc_sync[1];
         if (rd_rtc)
            rtc_int <= 1'b0; // ack beats a new tick
         else if (rtc_fall)
            rtc_int <= 1'b1;
      end
   end

   assign cass_out     = {~cass_reg[1], cass_reg[0]};
   assign cass_out_sel = wr_cass; // strobe for the duration of the write
endmodule

// ==== verilog/trs80_read_mux.sv ====
module trs80_read_mux (
   input  logic                         z80_clk,
   input  logic                         rd_n,
   input  logic [trs80_pkg::addr_w-1:0] addr,
   input  logic [trs80_pkg::data_w-1:0] keyb_row [8],
   input  logic                         kbd_sel,
   input  trs80_pkg::io_port_e          io_port,
   input  logic [trs80_pkg::data_w-1:0] int_mask,
   input  logic [trs80_pkg::data_w-1:0] nmi_mask,
   input  logic [5:0]                   mode_bits,
   input  logic                         rtc_int,
   input  logic                         cass_in,
   output logic [trs80_pkg::data_w-1:0] rd_data,
   output logic                         int_n,
   output logic                         nmi_n
);

   logic [trs80_pkg::data_w-1:0] kbd_next;
   logic [trs80_pkg::data_w-1:0] kbd_data;
   logic [trs80_pkg::data_w-1:0] int_stat; // 0 means pending
   logic [trs80_pkg::data_w-1:0] nmi_stat;
   logic [trs80_pkg::data_w-1:0] cass_stat;

   // each set address bit a0-a7 selects one keyboard row
   always_comb
   begin
      kbd_next = '0;
      for (int i = 0; i < 8; i++)
         kbd_next = kbd_next | ({trs80_pkg::data_w{addr[i]}} & keyb_row[i]);
   end

   always_ff @(posedge z80_clk)
      kbd_data <= kbd_next; // sampled every cycle, not only on reads

   assign int_stat  = ~{5'b00000, rtc_int, 2'b00}; // xio int, bit 3, never active
   assign nmi_stat  = '1;                           // no nmi sources left
   assign cass_stat = {cass_in, mode_bits, 1'b0};   // model 4 layout

   // a mask bit of 1 enables the source
   assign int_n = ~|(~int_stat & int_mask);
   assign nmi_n = ~|(~nmi_stat & nmi_mask);

   always_comb
   begin
      rd_data = trs80_pkg::open_bus;
      if (!rd_n)
      begin
         if (kbd_sel)
            rd_data = kbd_data;
         else
         begin
            case (io_port)
               trs80_pkg::port_int:       rd_data = int_stat;
               trs80_pkg::port_nmi:       rd_data = nmi_stat;
               trs80_pkg::port_fdc_stat:  rd_data = trs80_pkg::fdc_stat_val;
               trs80_pkg::port_fdc_track: rd_data = trs80_pkg::fdc_track_val;
               trs80_pkg::port_cass:      rd_data = cass_stat;
               default:                   rd_data = trs80_pkg::open_bus; // rom, ram, dsp outside
            endcase
         end
      end
   end
endmodule
